// ==== src/core_pkg.sv ====
package core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // host bridge
    ////////////////////////////////////////////////////////////////////////////

    // byte address as seen by the host
    typedef logic [31:0] bridge_addr_t;

    // one bridge data beat
    typedef logic [31:0] bridge_data_t;

    // word the host writes for debug and the overlay
    typedef logic [31:0] debug_word_t;

    // one access on the bridge
    // rd and wr are single-cycle strobes, no ack
    typedef struct packed {
        bridge_addr_t addr;
        logic         rd;
        logic         wr;
        bridge_data_t wr_data;
    } bridge_req_t;

    // top address byte of the register region
    localparam logic [7:0] REG_REGION = 8'h10;

    ////////////////////////////////////////////////////////////////////////////
    // cartridge port
    ////////////////////////////////////////////////////////////////////////////

    // one level translator bank
    typedef logic [7:0] cart_byte_t;

    // translator direction, 1 lets the FPGA drive
    localparam logic CART_DIR_OUT = 1'b1;

    // 74.25 MHz / 2 MHz rounded down
    localparam int CART_DIV_FACTOR = 37;

endpackage

// ==== src/av_pkg.sv ====
package av_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // video raster
    ////////////////////////////////////////////////////////////////////////////

    // one raster counter, wide enough for 512 lines
    typedef logic [9:0] raster_coord_t;

    // 400 clocks per line, 320 of them visible
    localparam raster_coord_t H_TOTAL  = 10'd400;
    localparam raster_coord_t H_ACTIVE = 10'd320;
    localparam raster_coord_t H_BPORCH = 10'd10;

    // 512 lines per frame, 240 visible
    localparam raster_coord_t V_TOTAL  = 10'd512;
    localparam raster_coord_t V_ACTIVE = 10'd240;
    localparam raster_coord_t V_BPORCH = 10'd10;

    // hs a few clocks after vs, never on the same cycle
    localparam raster_coord_t HS_COLUMN = 10'd3;

    // overlay band, raw counter coords, not visible coords
    localparam raster_coord_t OVERLAY_X_LIMIT = 10'd60;
    localparam raster_coord_t OVERLAY_Y_LIMIT = 10'd200;

    // background level per channel
    localparam logic [7:0] GREY_LEVEL = 8'd60;

    // {red, green, blue}
    typedef logic [23:0] pixel_t;

    // scaler video port
    typedef struct packed {
        pixel_t rgb;
        logic   de;
        logic   skip;
        logic   vs;
        logic   hs;
    } video_out_t;

    ////////////////////////////////////////////////////////////////////////////
    // audio clocking
    ////////////////////////////////////////////////////////////////////////////

    // mclk toggle rate = 2 * 12.288 MHz over 74.25 MHz
    typedef logic [21:0] mclk_accum_t;
    localparam mclk_accum_t MCLK_STEP = 22'd245760;
    localparam mclk_accum_t MCLK_WRAP = 22'd742500;

    // 32 sclk bits per channel
    localparam int LRCK_HALF_BITS = 32;

    // i2s port to the scaler
    typedef struct packed {
        logic mclk;
        logic lrck;
        logic dac;
    } audio_out_t;

endpackage

// ==== src/core_regs.sv ====
module core_regs
    import core_pkg::*;
(
    input  logic         clk_74a,
    input  logic         reset_n,
    input  bridge_req_t  bridge,
    output bridge_data_t rd_data,
    output debug_word_t  debug,
    output logic         overlay_en
);

    // address falls in the 0x10xxxxxx region
    logic region_hit;

    ////////////////////////////////////////////////////////////////////////////
    // region decode
    ////////////////////////////////////////////////////////////////////////////

    // only the top byte selects, lower bits alias
    assign region_hit = (bridge.addr[31:24] == REG_REGION);

    ////////////////////////////////////////////////////////////////////////////
    // debug word
    ////////////////////////////////////////////////////////////////////////////

    // wr strobe lands on this edge
    // new value shows up on every consumer next cycle
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            debug <= '0;
        end else if (bridge.wr && region_hit) begin
            debug <= bridge.wr_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////////////////////

    // reads have no side effect so the rd strobe is not decoded
    // data is valid in the same cycle as the address
    always_comb begin
        if (region_hit) begin
            rd_data = debug;
        end else begin
            // unmapped regions read as zero
            rd_data = '0;
        end
    end

    // overlay level for the video side
    // any set bit turns it on
    assign overlay_en = |debug;

endmodule

// ==== src/video_timing.sv ====
module video_timing
    import av_pkg::*;
(
    input  logic       clk_74a,
    input  logic       reset_n,
    input  logic       overlay_en,
    output video_out_t video
);

    // raw raster position, back porch included
    raster_coord_t h_count;
    raster_coord_t v_count;

    // inside the 320x240 window
    logic h_active;
    logic v_active;
    logic in_window;

    // pixel for the current position
    logic   overlay_hit;
    pixel_t pixel_next;

    ////////////////////////////////////////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////////////////////////////////////////

    // one pixel per clk_74a, 204800 clocks per frame
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == H_TOTAL - 1'b1) begin
            h_count <= '0;
            // end of line, step the row
            if (v_count == V_TOTAL - 1'b1) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // window and colour
    ////////////////////////////////////////////////////////////////////////////

    assign h_active  = (h_count >= H_BPORCH) && (h_count < H_BPORCH + H_ACTIVE);
    assign v_active  = (v_count >= V_BPORCH) && (v_count < V_BPORCH + V_ACTIVE);
    assign in_window = h_active && v_active;

    // left band and bottom band, raw coords
    assign overlay_hit = overlay_en &&
                         ((h_count < OVERLAY_X_LIMIT) || (v_count > OVERLAY_Y_LIMIT));

    always_comb begin
        if (overlay_hit) begin
            // solid red
            pixel_next = {8'hff, 8'h00, 8'h00};
        end else begin
            pixel_next = {GREY_LEVEL, GREY_LEVEL, GREY_LEVEL};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output stage
    ////////////////////////////////////////////////////////////////////////////

    // registered, one cycle behind the counters
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video <= '0;
        end else begin
            // frame origin
            video.vs   <= (h_count == '0) && (v_count == '0);
            // once per line, in the back porch
            video.hs   <= (h_count == HS_COLUMN);
            video.de   <= in_window;
            video.skip <= 1'b0;
            // blanking is black
            video.rgb  <= in_window ? pixel_next : '0;
        end
    end

endmodule

// ==== src/i2s_silence_gen.sv ====
module i2s_silence_gen
    import av_pkg::*;
(
    input  logic       clk_74a,
    input  logic       reset_n,
    output audio_out_t audio
);

    // fractional mclk source
    mclk_accum_t accum;
    logic        mclk;
    logic        mclk_toggle;
    logic        mclk_rise;

    // sclk is sclk_div[1], mclk / 4
    logic [1:0] sclk_div;
    logic       sclk_fall;

    // bit count within one channel
    logic [4:0] lrck_cnt;
    logic       lrck;

    ////////////////////////////////////////////////////////////////////////////
    // mclk, ~12.288 MHz from 74.25 MHz
    ////////////////////////////////////////////////////////////////////////////

    assign mclk_toggle = (accum >= MCLK_WRAP);

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            accum <= '0;
            mclk  <= 1'b0;
        end else if (mclk_toggle) begin
            accum <= accum - MCLK_WRAP + MCLK_STEP;
            mclk  <= ~mclk;
        end else begin
            accum <= accum + MCLK_STEP;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sclk and lrck, all on clk_74a
    ////////////////////////////////////////////////////////////////////////////

    // strobes mark the cycle the edge is produced
    assign mclk_rise = mclk_toggle && !mclk;
    // sclk_div 11 -> 00 takes bit 1 low
    assign sclk_fall = mclk_rise && (sclk_div == 2'b11);

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            sclk_div <= '0;
        end else if (mclk_rise) begin
            sclk_div <= sclk_div + 1'b1;
        end
    end

    // 32 sclk per channel, 128 mclk rises
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            lrck_cnt <= '0;
            lrck     <= 1'b0;
        end else if (sclk_fall) begin
            lrck_cnt <= lrck_cnt + 1'b1;
            if (int'(lrck_cnt) == LRCK_HALF_BITS - 1) begin
                // switch channels
                lrck <= ~lrck;
            end
        end
    end

    // data line stays silent
    assign audio = '{mclk: mclk, lrck: lrck, dac: 1'b0};

endmodule

// ==== src/cart_clock_div.sv ====
module cart_clock_div
    import core_pkg::*;
(
    input  logic clk_74a,
    input  logic reset_n,
    output logic cart_clk
);

    // cycles since the last toggle
    logic [$clog2(CART_DIV_FACTOR)-1:0] div_count;

    ////////////////////////////////////////////////////////////////////////////
    // toggle divider
    ////////////////////////////////////////////////////////////////////////////

    // ~1 MHz square wave for the cartridge pins
    // period is 2 * CART_DIV_FACTOR clocks
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            div_count <= '0;
            cart_clk  <= 1'b0;
        end else if (int'(div_count) == CART_DIV_FACTOR - 1) begin
            // wrap and flip
            div_count <= '0;
            cart_clk  <= ~cart_clk;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

endmodule

// ==== src/core_top.sv ====
module core_top
    import core_pkg::*;
    import av_pkg::*;
(
    input  logic         clk_74a,
    input  logic         reset_n,

    // host bridge
    input  bridge_req_t  bridge,
    output bridge_data_t bridge_rd_data,
    output logic         bridge_endian_little,

    // scaler video and i2s
    output video_out_t   video,
    output audio_out_t   audio,

    // cartridge translators
    output cart_byte_t   cart_bank3,
    output logic         cart_bank3_dir,
    output logic [3:0]   cart_bank0,
    output logic         cart_bank0_dir
);

    debug_word_t debug;
    logic        overlay_en;
    logic        cart_clk;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    core_regs i_core_regs (
        .clk_74a    (clk_74a),
        .reset_n    (reset_n),
        .bridge     (bridge),
        .rd_data    (bridge_rd_data),
        .debug      (debug),
        .overlay_en (overlay_en)
    );

    // host sees big-endian words
    assign bridge_endian_little = 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    video_timing i_video_timing (
        .clk_74a    (clk_74a),
        .reset_n    (reset_n),
        .overlay_en (overlay_en),
        .video      (video)
    );

    i2s_silence_gen i_i2s_silence_gen (
        .clk_74a (clk_74a),
        .reset_n (reset_n),
        .audio   (audio)
    );

    cart_clock_div i_cart_clock_div (
        .clk_74a  (clk_74a),
        .reset_n  (reset_n),
        .cart_clk (cart_clk)
    );

    ////////////////////////////////////////////////////////////////////////////
    // cartridge pins
    ////////////////////////////////////////////////////////////////////////////

    // low debug byte on AD[7:0] for a logic probe
    assign cart_bank3     = debug[7:0];
    assign cart_bank3_dir = CART_DIR_OUT;

    // test clock on PHI, WR, RD and CS alike
    assign cart_bank0     = {4{cart_clk}};
    assign cart_bank0_dir = CART_DIR_OUT;

endmodule

// ==== bench/core_top_properties.sv ====
module core_top_properties
    import av_pkg::*;
(
    input logic       clk_74a,
    input logic       reset_n,
    input video_out_t video,
    input audio_out_t audio,
    input logic [3:0] cart_bank0
);

    // failed checks, folded into the testbench summary
    int violations = 0;

    task automatic flag(input string what);
        violations++;
        $error("%s", what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // video port
    ////////////////////////////////////////////////////////////////////////////

    // sync pulses last one clock
    hs_pulse: assert property (@(posedge clk_74a) disable iff (!reset_n)
        video.hs |=> !video.hs)
        else flag("hs stayed high for more than one cycle");

    vs_pulse: assert property (@(posedge clk_74a) disable iff (!reset_n)
        video.vs |=> !video.vs)
        else flag("vs stayed high for more than one cycle");

    // blanking must be black
    blank_black: assert property (@(posedge clk_74a) disable iff (!reset_n)
        !video.de |-> (video.rgb == '0))
        else flag("rgb was not black outside the active window");

    ////////////////////////////////////////////////////////////////////////////
    // audio and cartridge
    ////////////////////////////////////////////////////////////////////////////

    dac_silent: assert property (@(posedge clk_74a) disable iff (!reset_n)
        !audio.dac)
        else flag("dac line went high");

    // one clock on all four bank 0 pins
    bank0_equal: assert property (@(posedge clk_74a) disable iff (!reset_n)
        cart_bank0 == {4{cart_bank0[0]}})
        else flag("cart_bank0 pins disagree");

endmodule

bind core_top core_top_properties i_props (.*);

// ==== bench/tb_core_top.sv ====
module tb_core_top
    import core_pkg::*;
    import av_pkg::*;
();

    localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int AUDIO_CYCLES = 100000;
    // worst case five frames of video tests, the audio window and some slack
    localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + AUDIO_CYCLES + 20000;

    // active window end, raw counter coords
    localparam int WIN_X_END = int'(H_BPORCH) + int'(H_ACTIVE);
    localparam int WIN_Y_END = int'(V_BPORCH) + int'(V_ACTIVE);
    localparam int ACTIVE_PIXELS = int'(H_ACTIVE) * int'(V_ACTIVE);
    // left band over all active rows, then bottom band right of it
    localparam int RED_PIXELS =
        (int'(OVERLAY_X_LIMIT) - int'(H_BPORCH)) * int'(V_ACTIVE) +
        (WIN_X_END - int'(OVERLAY_X_LIMIT)) * (WIN_Y_END - 1 - int'(OVERLAY_Y_LIMIT));
    localparam pixel_t GREY = {GREY_LEVEL, GREY_LEVEL, GREY_LEVEL};

    logic         clk_74a;
    logic         reset_n;
    bridge_req_t  bridge;
    bridge_data_t bridge_rd_data;
    logic         bridge_endian_little;
    video_out_t   video;
    audio_out_t   audio;
    cart_byte_t   cart_bank3;
    logic         cart_bank3_dir;
    logic [3:0]   cart_bank0;
    logic         cart_bank0_dir;

    int checks;
    int errors;
    int cycle_count;

    // stats of the last captured frame
    int frame_len;
    int hs_seen;
    int hs_gap_err;
    int de_lines;
    int de_run_err;
    int red_px;
    int grey_px;
    int odd_px;
    int skip_seen;

    core_top i_dut (.*);

    always #10 clk_74a = ~clk_74a;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic expect_equal(input string what, input longint got, input longint want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic report_test(input string name, input int start);
        $display("test %s done, %0d errors", name, errors - start);
    endtask

    // strobe for one cycle, the word updates on the next rising edge
    task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
        bridge.addr    = addr;
        bridge.wr_data = data;
        bridge.wr      = 1'b1;
        @(negedge clk_74a);
        bridge.wr = 1'b0;
    endtask

    task automatic bridge_read(input bridge_addr_t addr, output bridge_data_t data);
        bridge.addr = addr;
        bridge.rd   = 1'b1;
        // combinational, take it inside the low phase
        #5;
        data = bridge_rd_data;
        @(negedge clk_74a);
        bridge.rd = 1'b0;
    endtask

    task automatic wait_for_vs();
        while (!video.vs) @(negedge clk_74a);
    endtask

    // starts on a vs sample and stops on the next one
    // optionally loads the debug word in the first cycle
    task automatic capture_frame(input logic load, input debug_word_t value);
        int   n;
        int   last_hs;
        int   de_run;
        logic de_prev;
        n = 0;
        last_hs = -1;
        de_run = 0;
        de_prev = 1'b0;
        {frame_len, hs_seen, hs_gap_err, de_lines, de_run_err} = '0;
        {red_px, grey_px, odd_px, skip_seen} = '0;
        if (load) begin
            bridge.addr    = {REG_REGION, 24'h0};
            bridge.wr_data = value;
            bridge.wr      = 1'b1;
        end
        do begin
            if (video.hs) begin
                if (last_hs >= 0 && n - last_hs != int'(H_TOTAL)) hs_gap_err++;
                last_hs = n;
                hs_seen++;
            end
            if (video.skip) skip_seen++;
            if (video.de) begin
                de_run++;
                if (video.rgb == GREY) grey_px++;
                else if (video.rgb[23:16] != 0 && video.rgb[15:0] == 0) red_px++;
                else odd_px++;
            end else if (de_prev) begin
                // end of an active line
                if (de_run != int'(H_ACTIVE)) de_run_err++;
                de_lines++;
                de_run = 0;
            end
            de_prev = video.de;
            @(negedge clk_74a);
            bridge.wr = 1'b0;
            n++;
        end while (!video.vs && n < FRAME_CYCLES + 16);
        frame_len = n;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic register_access();
        int           start;
        bridge_data_t data;
        start = errors;
        bridge_read(32'h1000_0000, data);
        expect_equal("read after reset", data, 0);
        bridge_write(32'h1000_0000, 32'hdead_beef);
        bridge_read(32'h1000_0000, data);
        expect_equal("read back", data, 32'hdead_beef);
        // any address in the region aliases the word
        bridge_read(32'h10ab_cd04, data);
        expect_equal("read back at other region address", data, 32'hdead_beef);
        bridge_read(32'h2000_0000, data);
        expect_equal("unmapped read", data, 0);
        expect_equal("bridge_endian_little", bridge_endian_little, 0);
        bridge_write(32'h1000_0000, 32'h0);
        report_test("register access", start);
    endtask

    task automatic raster_geometry();
        int start;
        start = errors;
        wait_for_vs();
        capture_frame(1'b0, '0);
        expect_equal("vs spacing", frame_len, FRAME_CYCLES);
        expect_equal("hs pulses per frame", hs_seen, V_TOTAL);
        expect_equal("hs spacing faults", hs_gap_err, 0);
        expect_equal("active lines", de_lines, V_ACTIVE);
        expect_equal("de runs not 320 long", de_run_err, 0);
        expect_equal("cycles with skip high", skip_seen, 0);
        report_test("raster geometry", start);
    endtask

    task automatic overlay_colour();
        int start;
        start = errors;
        wait_for_vs();
        capture_frame(1'b1, '0);
        expect_equal("grey pixels, overlay off", grey_px, ACTIVE_PIXELS);
        // low byte zero, upper bit still turns the overlay on
        capture_frame(1'b1, 32'h0000_0100);
        expect_equal("red pixels", red_px, RED_PIXELS);
        expect_equal("grey pixels, overlay on", grey_px, ACTIVE_PIXELS - RED_PIXELS);
        expect_equal("pixels of other colour", odd_px, 0);
        capture_frame(1'b1, '0);
        expect_equal("grey pixels after clear", grey_px, ACTIVE_PIXELS);
        report_test("overlay colour", start);
    endtask

    task automatic cartridge_pins();
        int   start;
        int   since;
        int   toggles;
        logic prev;
        start = errors;
        bridge_write(32'h1000_0000, 32'h1234_565a);
        expect_equal("cart_bank3", cart_bank3, 8'h5a);
        bridge_write(32'h1000_0000, 32'h0000_00a5);
        expect_equal("cart_bank3", cart_bank3, 8'ha5);
        expect_equal("cart_bank3_dir", cart_bank3_dir, CART_DIR_OUT);
        expect_equal("cart_bank0_dir", cart_bank0_dir, CART_DIR_OUT);
        since = 0;
        toggles = 0;
        prev = cart_bank0[0];
        // exactly five toggles in five half periods, whatever the phase
        repeat (5 * CART_DIV_FACTOR) begin
            @(negedge clk_74a);
            since++;
            if (cart_bank0[0] != prev) begin
                if (toggles > 0) begin
                    expect_equal("cart clock half period", since, CART_DIV_FACTOR);
                end
                toggles++;
                since = 0;
            end
            prev = cart_bank0[0];
        end
        expect_equal("cart clock toggles", toggles, 5);
        report_test("cartridge pins", start);
    endtask

    task automatic audio_clocks();
        int     start;
        int     rises;
        int     since;
        int     toggles;
        int     lrck_off;
        logic   mclk_prev;
        logic   lrck_prev;
        longint wrap;
        longint half_step;
        longint err;
        start = errors;
        rises = 0;
        since = 0;
        toggles = 0;
        mclk_prev = audio.mclk;
        lrck_prev = audio.lrck;
        repeat (AUDIO_CYCLES) begin
            @(negedge clk_74a);
            if (audio.mclk && !mclk_prev) begin
                rises++;
                since++;
            end
            if (audio.lrck != lrck_prev) begin
                // 32 sclk per channel, 4 mclk per sclk
                if (toggles > 0) begin
                    expect_equal("mclk rises per lrck half", since, 4 * LRCK_HALF_BITS);
                end
                toggles++;
                since = 0;
            end
            expect_equal("dac", audio.dac, 0);
            mclk_prev = audio.mclk;
            lrck_prev = audio.lrck;
        end
        // rises should be cycles * (step / 2) / wrap, within one edge
        wrap = MCLK_WRAP;
        half_step = MCLK_STEP / 2;
        err = rises * wrap - AUDIO_CYCLES * half_step;
        expect_equal("mclk rate within one edge", (err <= wrap) && (err >= -wrap), 1);
        lrck_off = toggles - rises / 128;
        expect_equal("lrck toggle count", (lrck_off >= -1) && (lrck_off <= 1), 1);
        report_test("audio clocks", start);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk_74a = 1'b0;
        reset_n = 1'b0;
        bridge  = '0;
        checks  = 0;
        errors  = 0;
        repeat (4) @(negedge clk_74a);
        reset_n = 1'b1;
        @(negedge clk_74a);
        register_access();
        raster_geometry();
        overlay_colour();
        cartridge_pins();
        audio_clocks();
        errors += i_dut.i_props.violations;
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_74a);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
src/core_pkg.sv
src/av_pkg.sv
src/core_regs.sv
src/video_timing.sv
src/i2s_silence_gen.sv
src/cart_clock_div.sv
src/core_top.sv
bench/core_top_properties.sv
bench/tb_core_top.sv
